// ==== Makefile ====
# Verilator simulation of the L1 miss path

VERILATOR ?= verilator
TOP       ?= l1_miss_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/l1_consts.svh ====
/*
 * Word, line and address field widths of the L1 miss path
 */

`ifndef L1_CONSTS_SVH
`define L1_CONSTS_SVH

// ====================
// Data widths
// ====================

`define L1_WORD_W       32
`define L1_LINE_WORDS   8

// ====================
// Address fields
// ====================

// Word address, low to high: offset, index, tag
`define L1_OFFSET_W     3
`define L1_INDEX_W      7
`define L1_TAG_W        14

`endif

// ==== common/l1_pkg.sv ====
/*
 * Cache line, request, response and bus types
 * Tag and valid check with word select on a line
 */

`include "l1_consts.svh"

package l1_pkg;

    // ====================
    // Cache line
    // ====================

    // Layout {data, tag, valid} with valid in bit 0, 271 bits in all
    typedef struct packed {
        logic [`L1_LINE_WORDS-1:0][`L1_WORD_W-1:0] data;
        logic [`L1_TAG_W-1:0]                      tag;
        logic                                      valid;
    } l1_line_t;

    // ====================
    // Requests and results
    // ====================

    typedef struct packed {
        logic [`L1_WORD_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [`L1_WORD_W-1:0] addr;
        logic [`L1_WORD_W-1:0] wdata;
        logic                  we;
    } data_req_t;

    // One access on the backing-memory bus
    typedef struct packed {
        logic [`L1_WORD_W-1:0] addr;
        logic [`L1_WORD_W-1:0] data;
        logic                  we;
    } bus_req_t;

    // Hit is set only when the line supplied the word
    typedef struct packed {
        logic [`L1_WORD_W-1:0] word;
        logic                  hit;
    } word_rsp_t;

    // Tag compare and valid check, plus the word picked by the offset
    function automatic word_rsp_t line_match(input l1_line_t line,
                                             input logic [`L1_WORD_W-1:0] addr);
        word_rsp_t              res;
        logic [`L1_TAG_W-1:0]    tag;
        logic [`L1_OFFSET_W-1:0] offset;
        tag    = addr[`L1_OFFSET_W + `L1_INDEX_W +: `L1_TAG_W];
        offset = addr[`L1_OFFSET_W-1:0];
        res.hit  = line.valid && (line.tag == tag);
        res.word = line.data[offset];
        return res;
    endfunction

endpackage

// ==== dv/l1_miss_props.sv ====
/*
 * Strobe-rule assertions for the miss units and the bus arbiter
 */

`timescale 1ns/1ns

module l1_miss_props (
    input  logic clk,
    input  logic reset,
    input  logic req_valid,
    input  logic slot_busy,
    input  logic rsp_valid,
    input  logic mem_start,
    input  logic mem_done
);

    logic outstanding;

    // Bus access in flight between mem_start and mem_done
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_start) begin
            outstanding <= 1'b1;
        end else if (mem_done) begin
            outstanding <= 1'b0;
        end
    end

    a_no_req_when_busy: assert property (@(posedge clk) disable iff (reset)
        !(req_valid && slot_busy))
        else $error("request while slot busy");

    a_no_start_when_outstanding: assert property (@(posedge clk) disable iff (reset)
        !(mem_start && outstanding))
        else $error("mem_start while bus access outstanding");

    a_rsp_needs_busy: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> slot_busy)
        else $error("result strobe without busy slot");

endmodule

bind fetch_miss_unit l1_miss_props u_props (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .slot_busy (slot_busy),
    .rsp_valid (rsp_valid),
    .mem_start (1'b0),
    .mem_done  (1'b0)
);

bind data_miss_unit l1_miss_props u_props (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .slot_busy (slot_busy),
    .rsp_valid (rsp_valid),
    .mem_start (1'b0),
    .mem_done  (1'b0)
);

bind bus_arbiter l1_miss_props u_props (
    .clk       (clk),
    .reset     (reset),
    .req_valid (1'b0),
    .slot_busy (1'b1),
    .rsp_valid (1'b0),
    .mem_start (mem_start),
    .mem_done  (mem_done)
);

// ==== dv/l1_miss_tb.sv ====
/*
 * Testbench for l1_miss_top with line and memory models,
 * test file reader, compare tasks and timeout
 */

`timescale 1ns/1ns

module l1_miss_tb;

    import l1_pkg::*;

    `include "l1_consts.svh"

    localparam int MAX_TESTS = 64;

    logic clk;
    logic reset;

    logic       fetch_req_valid;
    fetch_req_t fetch_req;
    logic       fetch_rsp_valid;
    word_rsp_t  fetch_rsp;
    logic       data_req_valid;
    data_req_t  data_req;
    logic       data_rsp_valid;
    word_rsp_t  data_rsp;

    logic [`L1_INDEX_W-1:0] l1i_index;
    logic [`L1_INDEX_W-1:0] l1d_index;
    l1_line_t               l1i_line;
    l1_line_t               l1d_line;

    logic                  mem_start;
    bus_req_t              mem_req;
    logic                  mem_done;
    logic [`L1_WORD_W-1:0] mem_result;

    l1_line_t l1i_mem [2**`L1_INDEX_W];
    l1_line_t l1d_mem [2**`L1_INDEX_W];

    // Test table read from the data file
    int          ntests;
    int          port_a   [MAX_TESTS];
    int          next_a   [MAX_TESTS];
    data_req_t   req_a    [MAX_TESTS];
    word_rsp_t   exp_a    [MAX_TESTS];
    int          bus_on_a [MAX_TESTS];
    bus_req_t    bus_a    [MAX_TESTS];

    bus_req_t    obs_bus [$];
    int          cycles;
    int          limit;
    logic [31:0] rng;

    l1_miss_top DUT (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .l1i_index       (l1i_index),
        .l1i_line        (l1i_line),
        .l1d_index       (l1d_index),
        .l1d_line        (l1d_line),
        .mem_start       (mem_start),
        .mem_req         (mem_req),
        .mem_done        (mem_done),
        .mem_result      (mem_result)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Tag 0x100 + index, lines with index 3 mod 4 invalid
    function automatic l1_line_t make_line(input logic [7:0] side, input int i);
        l1_line_t ln;
        ln.tag   = 14'h100 + i[13:0];
        ln.valid = (i[1:0] != 2'b11);
        for (int o = 0; o < `L1_LINE_WORDS; o++) begin
            ln.data[o] = {side, 8'h00, 1'b0, i[6:0], 5'b0, o[2:0]};
        end
        return ln;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rsp(input string name, input word_rsp_t got, input word_rsp_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got word %h hit %b expected word %h hit %b",
                     $time, name, got.word, got.hit, exp.word, exp.hit);
            fail_now("response mismatch");
        end
    endtask

    task automatic check_bus(input string name, input bus_req_t got, input bus_req_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got addr %h data %h we %b expected addr %h data %h we %b",
                     $time, name, got.addr, got.data, got.we, exp.addr, exp.data, exp.we);
            fail_now("bus request mismatch");
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        logic [31:0] addr, wdata, eword, baddr, bdata;
        int    port, nxt, we, ehit, bon, bwe;
        fd = $fopen("dv/l1_miss_tests.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open the tests file");
        end
        ntests = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %d %h %d %d %h %h %d", port, nxt, addr, wdata,
                        we, eword, ehit, bon, baddr, bdata, bwe);
            if (n != 11) begin
                fail_now("malformed line in the tests file");
            end
            port_a[ntests]     = port;
            next_a[ntests]     = nxt;
            req_a[ntests].addr  = addr;
            req_a[ntests].wdata = wdata;
            req_a[ntests].we    = we[0];
            exp_a[ntests].word  = eword;
            exp_a[ntests].hit   = ehit[0];
            bus_on_a[ntests]    = bon;
            bus_a[ntests].addr  = baddr;
            bus_a[ntests].data  = bdata;
            bus_a[ntests].we    = bwe[0];
            ntests++;
        end
        $fclose(fd);
    endtask

    // ====================
    // Line and memory models
    // ====================

    // Index sampled one edge ahead so each line lands a cycle after its index
    logic [`L1_INDEX_W-1:0] l1i_index_q;
    logic [`L1_INDEX_W-1:0] l1d_index_q;

    always @(negedge clk) begin
        l1i_index_q <= l1i_index;
        l1d_index_q <= l1d_index;
        l1i_line    <= l1i_mem[l1i_index_q];
        l1d_line    <= l1d_mem[l1d_index_q];
    end

    int          mem_delay;
    logic        mem_busy;
    logic [31:0] mem_value;

    always @(negedge clk) begin
        mem_done <= 1'b0;
        if (reset) begin
            mem_busy = 1'b0;
        end else begin
            if (mem_busy) begin
                if (mem_delay == 1) begin
                    mem_done   <= 1'b1;
                    mem_result <= mem_value;
                    mem_busy = 1'b0;
                end else begin
                    mem_delay--;
                end
            end
            if (mem_start) begin
                obs_bus.push_back(mem_req);
                rng       = lcg_next(rng);
                mem_delay = 1 + int'(rng[17:16]);
                mem_value = mem_req.we ? mem_req.data : ~mem_req.addr;
                mem_busy  = 1'b1;
            end
        end
    end

    // Timeout on the cycle count
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            fail_now("timeout: the tests did not finish in time");
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial begin
        int t;
        int grp [$];
        int pend_f;
        int pend_d;
        int lat;
        int checked;
        bus_req_t exp_bus [$];
        clk             = 1'b0;
        reset           = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        data_req_valid  = 1'b0;
        data_req        = '0;
        l1i_line        = '0;
        l1d_line        = '0;
        mem_done        = 1'b0;
        mem_result      = '0;
        cycles          = 0;
        limit           = 0;
        checked         = 0;
        rng             = 32'hf8d6;
        mem_busy        = 1'b0;
        mem_delay       = 0;
        mem_value       = '0;
        for (int i = 0; i < 2**`L1_INDEX_W; i++) begin
            l1i_mem[i] = make_line(8'hA1, i);
            l1d_mem[i] = make_line(8'hD1, i);
        end
        read_tests();
        limit = ntests * 20;

        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Quiet after reset
        repeat (5) begin
            @(negedge clk);
            if (mem_start || fetch_rsp_valid || data_rsp_valid) begin
                fail_now("strobe seen after reset before any request");
            end
        end

        t = 0;
        while (t < ntests) begin
            grp.delete();
            exp_bus.delete();
            grp.push_back(t);
            if (next_a[t] != 0 && t + 1 < ntests) begin
                grp.push_back(t + 1);
            end
            t += grp.size();
            pend_f = -1;
            pend_d = -1;
            @(negedge clk);
            foreach (grp[k]) begin
                if (port_a[grp[k]] == 0) begin
                    pend_f          = grp[k];
                    fetch_req.addr  = req_a[grp[k]].addr;
                    fetch_req_valid = 1'b1;
                end else begin
                    pend_d         = grp[k];
                    data_req       = req_a[grp[k]];
                    data_req_valid = 1'b1;
                end
            end
            // Data side wins the bus
            if (pend_d >= 0 && bus_on_a[pend_d] != 0) begin
                exp_bus.push_back(bus_a[pend_d]);
            end
            if (pend_f >= 0 && bus_on_a[pend_f] != 0) begin
                exp_bus.push_back(bus_a[pend_f]);
            end
            lat = 0;
            while (pend_f >= 0 || pend_d >= 0) begin
                @(negedge clk);
                lat++;
                if (lat == 1) begin
                    fetch_req_valid = 1'b0;
                    data_req_valid  = 1'b0;
                end
                if (fetch_rsp_valid) begin
                    if (pend_f < 0) begin
                        fail_now("fetch result without a fetch request");
                    end
                    check_rsp("fetch_rsp", fetch_rsp, exp_a[pend_f]);
                    if (exp_a[pend_f].hit && lat != 3) begin
                        fail_now("fetch hit result not three cycles after the request");
                    end
                    pend_f = -1;
                end
                if (data_rsp_valid) begin
                    if (pend_d < 0) begin
                        fail_now("data result without a data request");
                    end
                    check_rsp("data_rsp", data_rsp, exp_a[pend_d]);
                    if (exp_a[pend_d].hit && lat != 3) begin
                        fail_now("data hit result not three cycles after the request");
                    end
                    pend_d = -1;
                end
            end
            if (obs_bus.size() - checked != exp_bus.size()) begin
                fail_now("wrong number of bus requests for a test");
            end
            foreach (exp_bus[k]) begin
                check_bus("mem_req", obs_bus[checked], exp_bus[k]);
                checked++;
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== dv/l1_miss_tests.txt ====
# port(0 fetch,1 data) with_next addr wdata we exp_word exp_hit
#   bus_expected bus_addr bus_data bus_we
0 0 0004142A 00000000 0 A1000502 1 0 00000000 00000000 0
0 0 FF040004 00000000 0 A1000004 1 0 00000000 00000000 0
0 0 0005FBF5 00000000 0 A1007E05 1 0 00000000 00000000 0
0 0 0004182A 00000000 0 FFFBE7D5 0 1 0004182A 00000000 0
0 0 00041C39 00000000 0 FFFBE3C6 0 1 00041C39 00000000 0
1 0 00042857 00000000 0 D1000A07 1 0 00000000 00000000 0
1 0 00042C57 00000000 0 FFFBD3A8 0 1 00042C57 00000000 0
1 0 0005FFFE 00000000 0 FFFA0001 0 1 0005FFFE 00000000 0
1 0 00042857 12345678 1 12345678 0 1 00042857 12345678 1
0 1 00080008 00000000 0 FFF7FFF7 0 1 00080008 00000000 0
1 0 00080013 00000000 0 FFF7FFEC 0 1 00080013 00000000 0
1 1 00042857 CAFEF00D 1 CAFEF00D 0 1 00042857 CAFEF00D 1
0 0 0004182A 00000000 0 FFFBE7D5 0 1 0004182A 00000000 0
1 1 00042857 00000000 0 D1000A07 1 0 00000000 00000000 0
0 0 0004142A 00000000 0 A1000502 1 0 00000000 00000000 0

// ==== l1_miss/data_miss_unit.sv ====
/*
 * Data-side L1d lookup with miss fetch and write-through
 * All bus traffic goes through the shared arbiter
 */

`timescale 1ns/1ns

`include "l1_consts.svh"

module data_miss_unit (
    input  logic                    clk,
    input  logic                    reset,

    // Request and result
    input  logic                    req_valid,
    input  l1_pkg::data_req_t       req,
    output logic                    rsp_valid,
    output l1_pkg::word_rsp_t       rsp,

    // L1d line port, read one cycle after the index
    output logic [`L1_INDEX_W-1:0]  index,
    input  l1_pkg::l1_line_t        line,

    // Toward the bus arbiter
    output logic                    need_bus,
    output l1_pkg::bus_req_t        bus_req,
    input  logic                    bus_done,
    input  logic [`L1_WORD_W-1:0]   bus_result
);

    import l1_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INDEX,
        ST_COMPARE,
        ST_WAIT_BUS,
        ST_RESPOND
    } state_t;

    state_t    state;
    data_req_t held;
    logic      slot_busy;
    logic      write_now;
    word_rsp_t lookup;
    word_rsp_t rsp_q;

    req_slot #(
        .payload_t (data_req_t)
    ) u_slot (
        .clk        (clk),
        .reset      (reset),
        .load       (req_valid),
        .payload_in (req),
        .clear      (rsp_valid),
        .payload    (held),
        .busy       (slot_busy)
    );

    assign index  = held.addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign lookup = line_match(line, held.addr);

    // A write skips the lookup and asks for the bus right away
    assign write_now = (state == ST_INDEX) && slot_busy && held.we;

    // ====================
    // Miss / write FSM
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_INDEX;
                    end
                end
                ST_INDEX: begin
                    if (write_now) begin
                        state <= ST_WAIT_BUS;
                    end else if (slot_busy) begin
                        state <= ST_COMPARE;
                    end
                end
                ST_COMPARE:  state <= lookup.hit ? ST_RESPOND : ST_WAIT_BUS;
                ST_WAIT_BUS: if (bus_done) state <= ST_RESPOND;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_COMPARE && lookup.hit) begin
            rsp_q <= lookup;
        end else if (state == ST_WAIT_BUS && bus_done) begin
            // Write-through result is whatever the memory returns
            rsp_q.word <= bus_result;
            rsp_q.hit  <= 1'b0;
        end
    end

    // Held steady from the first asking cycle until bus_done
    assign need_bus     = (state == ST_WAIT_BUS) || write_now;
    assign bus_req.addr = held.addr;
    assign bus_req.data = held.we ? held.wdata : '0;
    assign bus_req.we   = held.we;

    assign rsp_valid = (state == ST_RESPOND);
    assign rsp       = rsp_q;

endmodule

// ==== l1_miss/fetch_miss_unit.sv ====
/*
 * Instruction-side L1i lookup with miss fetch over the shared bus
 */

`timescale 1ns/1ns

`include "l1_consts.svh"

module fetch_miss_unit (
    input  logic                    clk,
    input  logic                    reset,

    // Request and result
    input  logic                    req_valid,
    input  l1_pkg::fetch_req_t      req,
    output logic                    rsp_valid,
    output l1_pkg::word_rsp_t       rsp,

    // L1i line port, read one cycle after the index
    output logic [`L1_INDEX_W-1:0]  index,
    input  l1_pkg::l1_line_t        line,

    // Toward the bus arbiter
    output logic                    need_bus,
    output l1_pkg::bus_req_t        bus_req,
    input  logic                    bus_done,
    input  logic [`L1_WORD_W-1:0]   bus_result
);

    import l1_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INDEX,
        ST_COMPARE,
        ST_WAIT_BUS,
        ST_RESPOND
    } state_t;

    state_t     state;
    fetch_req_t held;
    logic       slot_busy;
    word_rsp_t  lookup;
    word_rsp_t  rsp_q;

    req_slot #(
        .payload_t (fetch_req_t)
    ) u_slot (
        .clk        (clk),
        .reset      (reset),
        .load       (req_valid),
        .payload_in (req),
        .clear      (rsp_valid),
        .payload    (held),
        .busy       (slot_busy)
    );

    // Line select comes straight from the held address
    assign index  = held.addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign lookup = line_match(line, held.addr);

    // ====================
    // Miss FSM
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (req_valid) state <= ST_INDEX;
                ST_INDEX:    if (slot_busy) state <= ST_COMPARE;
                ST_COMPARE:  state <= lookup.hit ? ST_RESPOND : ST_WAIT_BUS;
                ST_WAIT_BUS: if (bus_done) state <= ST_RESPOND;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Result word, from the line on a hit or from the bus on a miss
    always_ff @(posedge clk) begin
        if (state == ST_COMPARE && lookup.hit) begin
            rsp_q <= lookup;
        end else if (state == ST_WAIT_BUS && bus_done) begin
            rsp_q.word <= bus_result;
            rsp_q.hit  <= 1'b0;
        end
    end

    assign need_bus     = (state == ST_WAIT_BUS);
    assign bus_req.addr = held.addr;
    assign bus_req.data = '0;
    assign bus_req.we   = 1'b0;

    assign rsp_valid = (state == ST_RESPOND);
    assign rsp       = rsp_q;

endmodule

// ==== l1_miss/l1_miss_top.sv ====
/*
 * L1 miss path top level with both units and the bus arbiter
 */

`timescale 1ns/1ns

`include "l1_consts.svh"

module l1_miss_top (
    input  logic                    clk,
    input  logic                    reset,

    // ====================
    // Fetch port
    // ====================
    input  logic                    fetch_req_valid,
    input  l1_pkg::fetch_req_t      fetch_req,
    output logic                    fetch_rsp_valid,
    output l1_pkg::word_rsp_t       fetch_rsp,

    // ====================
    // Data port
    // ====================
    input  logic                    data_req_valid,
    input  l1_pkg::data_req_t       data_req,
    output logic                    data_rsp_valid,
    output l1_pkg::word_rsp_t       data_rsp,

    // ====================
    // Line ports
    // ====================
    output logic [`L1_INDEX_W-1:0]  l1i_index,
    input  l1_pkg::l1_line_t        l1i_line,
    output logic [`L1_INDEX_W-1:0]  l1d_index,
    input  l1_pkg::l1_line_t        l1d_line,

    // ====================
    // Memory bus
    // ====================
    output logic                    mem_start,
    output l1_pkg::bus_req_t        mem_req,
    input  logic                    mem_done,
    input  logic [`L1_WORD_W-1:0]   mem_result
);

    import l1_pkg::*;

    logic     fetch_need;
    bus_req_t fetch_bus_req;
    logic     fetch_done;
    logic     data_need;
    bus_req_t data_bus_req;
    logic     data_done;

    fetch_miss_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (fetch_req_valid),
        .req        (fetch_req),
        .rsp_valid  (fetch_rsp_valid),
        .rsp        (fetch_rsp),
        .index      (l1i_index),
        .line       (l1i_line),
        .need_bus   (fetch_need),
        .bus_req    (fetch_bus_req),
        .bus_done   (fetch_done),
        .bus_result (mem_result)
    );

    data_miss_unit u_data (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (data_req_valid),
        .req        (data_req),
        .rsp_valid  (data_rsp_valid),
        .rsp        (data_rsp),
        .index      (l1d_index),
        .line       (l1d_line),
        .need_bus   (data_need),
        .bus_req    (data_bus_req),
        .bus_done   (data_done),
        .bus_result (mem_result)
    );

    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .d_need    (data_need),
        .d_req     (data_bus_req),
        .d_done    (data_done),
        .i_need    (fetch_need),
        .i_req     (fetch_bus_req),
        .i_done    (fetch_done),
        .mem_start (mem_start),
        .mem_req   (mem_req),
        .mem_done  (mem_done)
    );

endmodule

// ==== src/bus_arbiter.sv ====
/*
 * Fixed-priority owner of the backing-memory bus
 * Data side first, grant held until the done strobe
 */

`timescale 1ns/1ns

module bus_arbiter (
    input  logic              clk,
    input  logic              reset,

    // Data side
    input  logic              d_need,
    input  l1_pkg::bus_req_t  d_req,
    output logic              d_done,

    // Instruction side
    input  logic              i_need,
    input  l1_pkg::bus_req_t  i_req,
    output logic              i_done,

    // Backing memory
    output logic              mem_start,
    output l1_pkg::bus_req_t  mem_req,
    input  logic              mem_done
);

    import l1_pkg::*;

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_DATA,
        OWN_INSTR
    } owner_t;

    owner_t owner;
    logic   start_q;

    // ====================
    // Grant
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            owner   <= OWN_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (owner)
                OWN_IDLE: begin
                    // Data serves the older instruction
                    if (d_need) begin
                        owner   <= OWN_DATA;
                        start_q <= 1'b1;
                    end else if (i_need) begin
                        owner   <= OWN_INSTR;
                        start_q <= 1'b1;
                    end
                end
                default: begin
                    if (mem_done) begin
                        owner <= OWN_IDLE;
                    end
                end
            endcase
        end
    end

    // Requests are held steady by the owner until its done strobe
    assign mem_start = start_q;
    assign mem_req   = (owner == OWN_INSTR) ? i_req : d_req;

    // Route the done strobe back to whoever owns the bus
    assign d_done = mem_done && (owner == OWN_DATA);
    assign i_done = mem_done && (owner == OWN_INSTR);

endmodule

// ==== src/req_slot.sv ====
/*
 * Single-entry request holder, type-parameterized on the payload
 */

`timescale 1ns/1ns

module req_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    // Capture side
    input  logic     load,
    input  payload_t payload_in,

    // Result returned, slot may be reused
    input  logic     clear,

    output payload_t payload,
    output logic     busy
);

    payload_t payload_q;
    logic     busy_q;

    // Payload register, written only on capture
    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= payload_in;
        end
    end

    // Load wins over clear so a back-to-back request is not lost
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
        end else if (clear) begin
            busy_q <= 1'b0;
        end
    end

    assign payload = payload_q;
    assign busy    = busy_q;

endmodule

// ==== verilog.f ====
+incdir+common
common/l1_pkg.sv
src/req_slot.sv
src/bus_arbiter.sv
l1_miss/fetch_miss_unit.sv
l1_miss/data_miss_unit.sv
l1_miss/l1_miss_top.sv
dv/l1_miss_props.sv
dv/l1_miss_tb.sv
